/* hdl/axil_csr_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_csr_slave (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  emu_pkg::csr_addr_t   s_axil_awaddr,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    input  emu_pkg::csr_data_t   s_axil_wdata,
    input  emu_pkg::csr_strb_t   s_axil_wstrb,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,
    output emu_pkg::axil_resp_e  s_axil_bresp,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    input  emu_pkg::csr_addr_t   s_axil_araddr,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready,
    output emu_pkg::csr_data_t   s_axil_rdata,
    output emu_pkg::axil_resp_e  s_axil_rresp,

    output logic                 wr_en,
    output emu_pkg::csr_addr_t   wr_addr,
    output emu_pkg::csr_data_t   wr_data,
    output logic                 rd_en,
    output emu_pkg::csr_addr_t   rd_addr,
    input  emu_pkg::csr_data_t   rd_data
);

    import emu_pkg::*;

    // Ports open one cycle after reset is released
    logic       live;

    csr_addr_t  waddr_q;
    csr_data_t  wdata_q;
    logic       waddr_valid;
    logic       wdata_valid;
    logic       wstrb_err;
    logic       bvalid_q;
    axil_resp_e bresp_q;
    logic       wr_both;

    csr_addr_t  raddr_q;
    csr_data_t  rdata_q;
    logic       raddr_valid;
    logic       rdata_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    // Write path: AW and W are captured independently
    assign wr_both = waddr_valid && wdata_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            waddr_valid <= 1'b0;
            wdata_valid <= 1'b0;
            wstrb_err   <= 1'b0;
            bvalid_q    <= 1'b0;
            bresp_q     <= RESP_OKAY;
        end else begin
            if (s_axil_awvalid && s_axil_awready) begin
                waddr_valid <= 1'b1;
            end
            if (s_axil_wvalid && s_axil_wready) begin
                wdata_valid <= 1'b1;
                // Only full-word writes are accepted
                wstrb_err   <= s_axil_wstrb != '1;
            end
            if (wr_both) begin
                waddr_valid <= 1'b0;
                wdata_valid <= 1'b0;
                bvalid_q    <= 1'b1;
                bresp_q     <= wstrb_err ? RESP_SLVERR : RESP_OKAY;
            end
            if (s_axil_bvalid && s_axil_bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_axil_awvalid && s_axil_awready) begin
            waddr_q <= s_axil_awaddr;
        end
        if (s_axil_wvalid && s_axil_wready) begin
            wdata_q <= s_axil_wdata;
        end
    end

    assign s_axil_awready = live && !waddr_valid && !bvalid_q;
    assign s_axil_wready  = live && !wdata_valid;
    assign s_axil_bvalid  = bvalid_q;
    assign s_axil_bresp   = bresp_q;

    assign wr_en   = wr_both && !wstrb_err;
    assign wr_addr = waddr_q;
    assign wr_data = wdata_q;

    // Read path, bank is sampled in the cycle after AR
    assign rd_en   = raddr_valid && !rdata_valid;
    assign rd_addr = raddr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            raddr_valid <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            if (s_axil_arvalid && s_axil_arready) begin
                raddr_valid <= 1'b1;
            end
            if (rd_en) begin
                rdata_valid <= 1'b1;
            end
            if (s_axil_rvalid && s_axil_rready) begin
                raddr_valid <= 1'b0;
                rdata_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_axil_arvalid && s_axil_arready) begin
            raddr_q <= s_axil_araddr;
        end
        if (rd_en) begin
            rdata_q <= rd_data;
        end
    end

    assign s_axil_arready = live && !raddr_valid;
    assign s_axil_rvalid  = rdata_valid;
    assign s_axil_rdata   = rdata_q;
    assign s_axil_rresp   = RESP_OKAY;

endmodule

`default_nettype wire

/* hdl/emu_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module emu_controller (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  emu_pkg::csr_addr_t   s_axil_awaddr,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    input  emu_pkg::csr_data_t   s_axil_wdata,
    input  emu_pkg::csr_strb_t   s_axil_wstrb,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,
    output emu_pkg::axil_resp_e  s_axil_bresp,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    input  emu_pkg::csr_addr_t   s_axil_araddr,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready,
    output emu_pkg::csr_data_t   s_axil_rdata,
    output emu_pkg::axil_resp_e  s_axil_rresp,

    input  emu_pkg::trig_vec_t   dut_trig,
    input  logic                 stall_gen,
    input  logic                 putchar_valid,
    input  logic [7:0]           putchar_data,
    output logic                 putchar_ready,
    output logic                 dut_clk_en,
    output logic                 dut_rst
);

    import emu_pkg::*;

    // Register bank strobes
    logic      wr_en;
    csr_addr_t wr_addr;
    csr_data_t wr_data;
    logic      rd_en;
    csr_addr_t rd_addr;
    csr_data_t rd_data;

    // Run control interface
    logic      stat_wr;
    logic      cycle_lo_wr;
    logic      cycle_hi_wr;
    logic      step_wr;
    trig_vec_t trig_en;
    logic      pause;
    logic      step_trig;
    cycle_t    cycle;
    csr_data_t step;

    axil_csr_slave u_slave (
        .clk            (clk),
        .rst            (rst),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data)
    );

    emu_csr_bank u_bank (
        .clk           (clk),
        .rst           (rst),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .dut_trig      (dut_trig),
        .putchar_valid (putchar_valid),
        .putchar_data  (putchar_data),
        .putchar_ready (putchar_ready),
        .pause         (pause),
        .dut_rst       (dut_rst),
        .step_trig     (step_trig),
        .cycle         (cycle),
        .step          (step),
        .stat_wr       (stat_wr),
        .cycle_lo_wr   (cycle_lo_wr),
        .cycle_hi_wr   (cycle_hi_wr),
        .step_wr       (step_wr),
        .trig_en       (trig_en)
    );

    emu_run_ctrl u_run_ctrl (
        .clk         (clk),
        .rst         (rst),
        .stat_wr     (stat_wr),
        .cycle_lo_wr (cycle_lo_wr),
        .cycle_hi_wr (cycle_hi_wr),
        .step_wr     (step_wr),
        .wr_data     (wr_data),
        .trig_en     (trig_en),
        .dut_trig    (dut_trig),
        .stall_gen   (stall_gen),
        .pause       (pause),
        .dut_rst     (dut_rst),
        .step_trig   (step_trig),
        .cycle       (cycle),
        .step        (step),
        .dut_clk_en  (dut_clk_en)
    );

endmodule

`default_nettype wire

/* hdl/emu_csr_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module emu_csr_bank (
    input  logic                clk,
    input  logic                rst,

    input  logic                wr_en,
    input  emu_pkg::csr_addr_t  wr_addr,
    input  emu_pkg::csr_data_t  wr_data,
    input  logic                rd_en,
    input  emu_pkg::csr_addr_t  rd_addr,
    output emu_pkg::csr_data_t  rd_data,

    input  emu_pkg::trig_vec_t  dut_trig,
    input  logic                putchar_valid,
    input  logic [7:0]          putchar_data,
    output logic                putchar_ready,

    input  logic                pause,
    input  logic                dut_rst,
    input  logic                step_trig,
    input  emu_pkg::cycle_t     cycle,
    input  emu_pkg::csr_data_t  step,

    output logic                stat_wr,
    output logic                cycle_lo_wr,
    output logic                cycle_hi_wr,
    output logic                step_wr,
    output emu_pkg::trig_vec_t  trig_en
);

    import emu_pkg::*;

    trig_vec_t trig_stat;
    logic      trig_en_wr;
    csr_data_t stat_word;
    csr_data_t putchar_word;

    // Per-register write strobes
    assign stat_wr     = wr_en && wr_addr == REG_STAT;
    assign cycle_lo_wr = wr_en && wr_addr == REG_CYCLE_LO;
    assign cycle_hi_wr = wr_en && wr_addr == REG_CYCLE_HI;
    assign step_wr     = wr_en && wr_addr == REG_STEP;
    assign trig_en_wr  = wr_en && wr_addr == REG_TRIG_EN;

    always_ff @(posedge clk) begin
        if (rst) begin
            trig_en   <= '0;
            trig_stat <= '0;
        end else begin
            if (trig_en_wr) begin
                trig_en <= wr_data;
            end
            // One cycle behind the DUT
            trig_stat <= dut_trig;
        end
    end

    always_comb begin
        stat_word                     = '0;
        stat_word[STAT_PAUSE_BIT]     = pause;
        stat_word[STAT_DUT_RST_BIT]   = dut_rst;
        stat_word[STAT_STEP_TRIG_BIT] = step_trig;
    end

    always_comb begin
        putchar_word                    = '0;
        putchar_word[PUTCHAR_VALID_BIT] = putchar_valid;
        putchar_word[7:0]               = putchar_data;
    end

    // Read mux, unmapped offsets return zero
    always_comb begin
        case (rd_addr)
            REG_STAT:      rd_data = stat_word;
            REG_TRIG_STAT: rd_data = trig_stat;
            REG_CYCLE_LO:  rd_data = cycle[CSR_DATA_W-1:0];
            REG_CYCLE_HI:  rd_data = cycle[CYCLE_W-1:CSR_DATA_W];
            REG_STEP:      rd_data = step;
            REG_TRIG_EN:   rd_data = trig_en;
            REG_PUTCHAR:   rd_data = putchar_word;
            default:       rd_data = '0;
        endcase
    end

    // Pop the character in the cycle it is sampled
    assign putchar_ready = rd_en && rd_addr == REG_PUTCHAR;

endmodule

`default_nettype wire

/* hdl/emu_pkg.sv */
`default_nettype none

package emu_pkg;

    // Register port geometry
    localparam int CSR_ADDR_W = 12;
    localparam int CSR_DATA_W = 32;
    localparam int CSR_STRB_W = 4;

    // DUT side
    localparam int NUM_TRIG = 32;
    localparam int CYCLE_W  = 64;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;
    typedef logic [CSR_STRB_W-1:0] csr_strb_t;
    typedef logic [NUM_TRIG-1:0]   trig_vec_t;
    typedef logic [CYCLE_W-1:0]    cycle_t;

    // Register map, byte offsets
    typedef enum csr_addr_t {
        REG_STAT      = 12'h000,
        REG_TRIG_STAT = 12'h004,
        REG_CYCLE_LO  = 12'h008,
        REG_CYCLE_HI  = 12'h00C,
        REG_STEP      = 12'h010,
        REG_TRIG_EN   = 12'h014,
        REG_PUTCHAR   = 12'h018
    } emu_reg_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // STAT fields
    localparam int STAT_PAUSE_BIT     = 0;
    localparam int STAT_DUT_RST_BIT   = 1;
    // Read only, set when the last pause came from the step counter
    localparam int STAT_STEP_TRIG_BIT = 31;

    // PUTCHAR fields, character in 7:0
    localparam int PUTCHAR_VALID_BIT = 31;

endpackage

`default_nettype wire

/* hdl/emu_run_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module emu_run_ctrl (
    input  logic                clk,
    input  logic                rst,

    input  logic                stat_wr,
    input  logic                cycle_lo_wr,
    input  logic                cycle_hi_wr,
    input  logic                step_wr,
    input  emu_pkg::csr_data_t  wr_data,
    input  emu_pkg::trig_vec_t  trig_en,

    input  emu_pkg::trig_vec_t  dut_trig,
    input  logic                stall_gen,

    output logic                pause,
    output logic                dut_rst,
    output logic                step_trig,
    output emu_pkg::cycle_t     cycle,
    output emu_pkg::csr_data_t  step,
    output logic                dut_clk_en
);

    import emu_pkg::*;

    csr_data_t step_next;
    logic      step_event;
    logic      trig_event;
    logic      pause_event;

    // DUT advances only when not paused and not stalled
    assign dut_clk_en = !pause && !stall_gen;

    always_comb begin
        if (dut_clk_en && step != '0) begin
            step_next = step - csr_data_t'(1);
        end else begin
            step_next = step;
        end
    end

    // Countdown reaches zero this cycle
    assign step_event  = step != '0 && step_next == '0;
    assign trig_event  = |(dut_trig & trig_en);
    assign pause_event = step_event || trig_event;

    always_ff @(posedge clk) begin
        if (rst) begin
            pause     <= 1'b1;
            dut_rst   <= 1'b1;
            step_trig <= 1'b0;
        end else begin
            if (stat_wr) begin
                pause   <= wr_data[STAT_PAUSE_BIT];
                dut_rst <= wr_data[STAT_DUT_RST_BIT];
            end
            // Overrides a software clear of pause in the same cycle
            if (pause_event) begin
                pause     <= 1'b1;
                step_trig <= step_event;
            end
        end
    end

    // Cycle counter, writable only while the DUT is stopped
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (dut_clk_en) begin
            cycle <= cycle + cycle_t'(1);
        end else begin
            if (cycle_lo_wr) begin
                cycle[CSR_DATA_W-1:0] <= wr_data;
            end
            if (cycle_hi_wr) begin
                cycle[CYCLE_W-1:CSR_DATA_W] <= wr_data;
            end
        end
    end

    // Software load wins over the countdown
    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (step_wr) begin
            step <= wr_data;
        end else begin
            step <= step_next;
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+test
hdl/emu_pkg.sv
hdl/axil_csr_slave.sv
hdl/emu_run_ctrl.sv
hdl/emu_csr_bank.sv
hdl/emu_controller.sv
test/tb_emu_controller.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f project.f \
    --top-module tb_emu_controller \
    -Mdir obj_dir

./obj_dir/Vtb_emu_controller > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

/* test/tb_emu_tasks.svh */
`ifndef TB_EMU_TASKS_SVH
`define TB_EMU_TASKS_SVH

// Bus tasks drive on the rising edge and sample on the falling edge

task automatic axil_write(input csr_addr_t addr, input csr_data_t data,
                          input csr_strb_t strb, output axil_resp_e resp);
    logic aw_pend;
    logic w_pend;
    logic aw_fire;
    logic w_fire;
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    @(posedge clk);
    s_axil_awvalid <= 1'b1;
    s_axil_awaddr  <= addr;
    s_axil_wvalid  <= 1'b1;
    s_axil_wdata   <= data;
    s_axil_wstrb   <= strb;
    s_axil_bready  <= 1'b1;
    while (aw_pend || w_pend) begin
        @(negedge clk);
        // Handshakes complete at the coming edge
        aw_fire = aw_pend && s_axil_awready;
        w_fire  = w_pend && s_axil_wready;
        @(posedge clk);
        if (aw_fire) begin
            s_axil_awvalid <= 1'b0;
            aw_pend = 1'b0;
        end
        if (w_fire) begin
            s_axil_wvalid <= 1'b0;
            w_pend = 1'b0;
        end
    end
    do begin
        @(negedge clk);
    end while (!s_axil_bvalid);
    resp = s_axil_bresp;
    @(posedge clk);
    s_axil_bready <= 1'b0;
endtask

task automatic axil_read(input csr_addr_t addr, output csr_data_t data);
    @(posedge clk);
    s_axil_arvalid <= 1'b1;
    s_axil_araddr  <= addr;
    s_axil_rready  <= 1'b1;
    do begin
        @(negedge clk);
    end while (!s_axil_arready);
    @(posedge clk);
    s_axil_arvalid <= 1'b0;
    do begin
        @(negedge clk);
    end while (!s_axil_rvalid);
    data = s_axil_rdata;
    check_resp("rresp", s_axil_rresp, RESP_OKAY);
    @(posedge clk);
    s_axil_rready <= 1'b0;
endtask

task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
    check_count = check_count + 1;
    if (got !== exp) begin
        error_count = error_count + 1;
        $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
    end
endtask

task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
    check_count = check_count + 1;
    if (got !== exp) begin
        error_count = error_count + 1;
        $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    check_count = check_count + 1;
    if (got !== exp) begin
        error_count = error_count + 1;
        $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
endtask

// Full-word write that must be accepted
task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
    axil_resp_e resp;
    axil_write(addr, data, '1, resp);
    check_resp("bresp", resp, RESP_OKAY);
endtask

task automatic expect_reg(input string name, input csr_addr_t addr, input csr_data_t exp);
    csr_data_t value;
    axil_read(addr, value);
    check_data(name, value, exp);
endtask

task automatic wait_pause(input string name, output csr_data_t stat);
    int polls;
    polls = 0;
    axil_read(REG_STAT, stat);
    while (!stat[STAT_PAUSE_BIT] && polls < 50) begin
        axil_read(REG_STAT, stat);
        polls = polls + 1;
    end
    if (!stat[STAT_PAUSE_BIT]) begin
        error_count = error_count + 1;
        $display("%s: the DUT never paused after %0d status reads", name, polls);
    end
endtask

task automatic report_test(input string name, input int errors_before);
    test_count = test_count + 1;
    if (error_count == errors_before) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, error_count - errors_before);
    end
endtask

task automatic verify_reset();
    int        errors_before;
    csr_data_t stat;
    errors_before = error_count;
    axil_read(REG_STAT, stat);
    check_data("STAT", stat, 32'h0000_0003);
    expect_reg("CYCLE_LO", REG_CYCLE_LO, '0);
    expect_reg("STEP", REG_STEP, '0);
    expect_reg("TRIG_EN", REG_TRIG_EN, '0);
    @(negedge clk);
    // Paused and held in reset
    check_bit("dut_clk_en", dut_clk_en, 1'b0);
    check_bit("dut_rst", dut_rst, 1'b1);
    report_test("reset values", errors_before);
endtask

task automatic exercise_registers();
    int         errors_before;
    csr_data_t  trig_val;
    csr_data_t  cyc_val;
    axil_resp_e resp;
    errors_before = error_count;
    trig_val = $random(seed);
    cyc_val  = $random(seed);
    write_reg(REG_TRIG_EN, trig_val);
    expect_reg("TRIG_EN", REG_TRIG_EN, trig_val);
    // Still paused, so the counter accepts the write
    write_reg(REG_CYCLE_LO, cyc_val);
    expect_reg("CYCLE_LO", REG_CYCLE_LO, cyc_val);
    axil_write(REG_TRIG_EN, ~trig_val, 4'b0011, resp);
    check_resp("bresp partial strobe", resp, RESP_SLVERR);
    expect_reg("TRIG_EN after partial strobe", REG_TRIG_EN, trig_val);
    expect_reg("unmapped 0x100", 12'h100, '0);
    write_reg(REG_TRIG_EN, '0);
    report_test("register access", errors_before);
endtask

task automatic run_fixed_steps();
    int        errors_before;
    csr_data_t start;
    csr_data_t steps;
    csr_data_t stat;
    errors_before = error_count;
    start = $random(seed);
    steps = 1 + ($unsigned($random(seed)) % 20);
    write_reg(REG_CYCLE_LO, start);
    write_reg(REG_STEP, steps);
    write_reg(REG_STAT, '0);
    wait_pause("step run", stat);
    // Paused by the step counter with the DUT reset released
    check_data("STAT", stat, 32'h8000_0001);
    expect_reg("CYCLE_LO", REG_CYCLE_LO, start + steps);
    expect_reg("STEP", REG_STEP, '0);
    @(negedge clk);
    check_bit("dut_clk_en", dut_clk_en, 1'b0);
    check_bit("dut_rst", dut_rst, 1'b0);
    report_test("step run", errors_before);
endtask

task automatic trigger_pause();
    int        errors_before;
    int        k;
    int        j;
    csr_data_t stat;
    errors_before = error_count;
    k = $unsigned($random(seed)) % 32;
    j = (k + 1 + ($unsigned($random(seed)) % 31)) % 32;
    write_reg(REG_TRIG_EN, csr_data_t'(1) << k);
    write_reg(REG_STAT, '0);
    @(posedge clk);
    dut_trig <= trig_vec_t'(1) << j;
    repeat (4) begin
        @(negedge clk);
        check_bit("dut_clk_en with masked trigger", dut_clk_en, 1'b1);
    end
    axil_read(REG_STAT, stat);
    check_bit("STAT pause with masked trigger", stat[STAT_PAUSE_BIT], 1'b0);
    expect_reg("TRIG_STAT masked", REG_TRIG_STAT, csr_data_t'(1) << j);
    @(posedge clk);
    dut_trig <= trig_vec_t'(1) << k;
    // Pause lands on the edge after the trigger is seen
    @(posedge clk);
    @(negedge clk);
    check_bit("dut_clk_en after trigger", dut_clk_en, 1'b0);
    axil_read(REG_STAT, stat);
    check_data("STAT after trigger", stat, 32'h0000_0001);
    expect_reg("TRIG_STAT enabled", REG_TRIG_STAT, csr_data_t'(1) << k);
    @(posedge clk);
    dut_trig <= '0;
    write_reg(REG_TRIG_EN, '0);
    report_test("triggers", errors_before);
endtask

task automatic stall_run();
    int        errors_before;
    csr_data_t start;
    csr_data_t steps;
    csr_data_t stat;
    errors_before = error_count;
    steps = 1 + ($unsigned($random(seed)) % 20);
    start = $random(seed);
    write_reg(REG_STEP, steps);
    // Still paused by the trigger, so the counter accepts the write
    write_reg(REG_CYCLE_LO, start);
    @(posedge clk);
    stall_gen <= 1'b1;
    write_reg(REG_STAT, '0);
    repeat (4) begin
        @(negedge clk);
        check_bit("dut_clk_en while stalled", dut_clk_en, 1'b0);
    end
    expect_reg("STEP while stalled", REG_STEP, steps);
    expect_reg("CYCLE_LO while stalled", REG_CYCLE_LO, start);
    axil_read(REG_STAT, stat);
    check_bit("STAT pause while stalled", stat[STAT_PAUSE_BIT], 1'b0);
    @(posedge clk);
    stall_gen <= 1'b0;
    wait_pause("stall run", stat);
    check_data("STAT", stat, 32'h8000_0001);
    expect_reg("CYCLE_LO", REG_CYCLE_LO, start + steps);
    expect_reg("STEP", REG_STEP, '0);
    report_test("stall input", errors_before);
endtask

task automatic read_putchar();
    int         errors_before;
    int         pops_before;
    logic [7:0] ch;
    csr_data_t  exp;
    csr_data_t  value;
    errors_before = error_count;
    ch = 8'($random(seed));
    exp = '0;
    exp[PUTCHAR_VALID_BIT] = 1'b1;
    exp[7:0] = ch;
    @(posedge clk);
    putchar_valid <= 1'b1;
    putchar_data  <= ch;
    pops_before = pop_count;
    axil_read(REG_PUTCHAR, value);
    check_data("PUTCHAR", value, exp);
    check_data("putchar_ready pulses", csr_data_t'(pop_count - pops_before), 32'd1);
    @(posedge clk);
    putchar_valid <= 1'b0;
    report_test("putchar", errors_before);
endtask

`endif

/* test/tb_emu_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_emu_controller;

    import emu_pkg::*;

    // Six tests of a few dozen bus transfers, about five cycles each, plus status polling
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk;
    logic       rst;

    logic       s_axil_awvalid;
    logic       s_axil_awready;
    csr_addr_t  s_axil_awaddr;
    logic       s_axil_wvalid;
    logic       s_axil_wready;
    csr_data_t  s_axil_wdata;
    csr_strb_t  s_axil_wstrb;
    logic       s_axil_bvalid;
    logic       s_axil_bready;
    axil_resp_e s_axil_bresp;
    logic       s_axil_arvalid;
    logic       s_axil_arready;
    csr_addr_t  s_axil_araddr;
    logic       s_axil_rvalid;
    logic       s_axil_rready;
    csr_data_t  s_axil_rdata;
    axil_resp_e s_axil_rresp;

    trig_vec_t  dut_trig;
    logic       stall_gen;
    logic       putchar_valid;
    logic [7:0] putchar_data;
    logic       putchar_ready;
    logic       dut_clk_en;
    logic       dut_rst;

    integer     seed;
    int         error_count;
    int         check_count;
    int         test_count;
    int         tb_cycles;
    int         pop_count;

    emu_controller DUT (
        .clk            (clk),
        .rst            (rst),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .dut_trig       (dut_trig),
        .stall_gen      (stall_gen),
        .putchar_valid  (putchar_valid),
        .putchar_data   (putchar_data),
        .putchar_ready  (putchar_ready),
        .dut_clk_en     (dut_clk_en),
        .dut_rst        (dut_rst)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        tb_cycles <= tb_cycles + 1;
        if (tb_cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Count putchar pops in the middle of the cycle
    always @(negedge clk) begin
        if (putchar_ready) begin
            pop_count <= pop_count + 1;
        end
    end

    `include "tb_emu_tasks.svh"

    initial begin
        seed        = 32'h34c1_b736;
        error_count = 0;
        check_count = 0;
        test_count  = 0;

        rst            <= 1'b1;
        s_axil_awvalid <= 1'b0;
        s_axil_awaddr  <= '0;
        s_axil_wvalid  <= 1'b0;
        s_axil_wdata   <= '0;
        s_axil_wstrb   <= '0;
        s_axil_bready  <= 1'b0;
        s_axil_arvalid <= 1'b0;
        s_axil_araddr  <= '0;
        s_axil_rready  <= 1'b0;
        dut_trig       <= '0;
        stall_gen      <= 1'b0;
        putchar_valid  <= 1'b0;
        putchar_data   <= '0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        verify_reset();
        exercise_registers();
        run_fixed_steps();
        trigger_pause();
        stall_run();
        read_putchar();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
